//--- hw/clkPkg.sv
package clkPkg;

  // Widths fixed by the register map
  localparam int SEL_W   = 3;
  localparam int LD_W    = 4;
  localparam int BURST_W = 8;
  localparam int DIAG_W  = 6;

  // Control functions on the diagnostic select
  // Codes 3 and 4 are EBOX step variants with no effect here
  localparam logic [SEL_W-1:0] FN_START       = 3'd1;
  localparam logic [SEL_W-1:0] FN_SINGLE_STEP = 3'd2;
  localparam logic [SEL_W-1:0] FN_BURST       = 3'd5;
  localparam logic [SEL_W-1:0] FN_CLR_RESET   = 3'd6;
  localparam logic [SEL_W-1:0] FN_SET_RESET   = 3'd7;

  // Load functions 042..047
  localparam logic [SEL_W-1:0] LD_BURST_LO = 3'd2;
  localparam logic [SEL_W-1:0] LD_BURST_HI = 3'd3;
  localparam logic [SEL_W-1:0] LD_CLK_SEL  = 3'd4;
  localparam logic [SEL_W-1:0] LD_DISABLE  = 3'd5;
  localparam logic [SEL_W-1:0] LD_CHECK    = 3'd6;
  localparam logic [SEL_W-1:0] LD_MBOX_CTL = 3'd7;

  // Load 044 layout
  typedef struct packed {
    logic [1:0] sourceSel;
    logic [1:0] rateSel;
  } clkSelT;

  // Load 045 layout, top bit unused
  typedef struct packed {
    logic spare;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } disablesT;

  // Load 046 layout
  typedef struct packed {
    logic fmParChk;
    logic cramParChk;
    logic dramParChk;
    logic fsChk;
  } checksT;

  // Load 047 layout
  typedef struct packed {
    logic cycleDis;
    logic respSim;
    logic arArxParChk;
    logic errStopEn;
  } mboxCtlT;

  // One load nibble, read according to the load function
  typedef union packed {
    clkSelT          clkSel;
    disablesT        disables;
    checksT          checks;
    mboxCtlT         mboxCtl;
    logic [LD_W-1:0] raw;
  } ldFieldU;

  // Diagnostic readback rows
  localparam logic [SEL_W-1:0] ROW_RUN      = 3'd0;
  localparam logic [SEL_W-1:0] ROW_BURST_LO = 3'd1;
  localparam logic [SEL_W-1:0] ROW_CLK_SEL  = 3'd2;
  localparam logic [SEL_W-1:0] ROW_DIS_CHK  = 3'd3;
  localparam logic [SEL_W-1:0] ROW_MBOX     = 3'd4;

endpackage

//--- hw/clkFuncDecoder.sv
`timescale 1ns/1ps

module clkFuncDecoder import clkPkg::*; (
  input  logic             MBOX_CLK,
  input  logic             CLK,
  input  logic             diagCtlFunc,
  input  logic             diagLdFunc,
  input  logic [SEL_W-1:0] diagSel,
  input  logic [LD_W-1:0]  ebusData,
  output logic             ctlStrobe,
  output logic [SEL_W-1:0] ctlCode,
  output logic             ld042,
  output logic             ld043,
  output logic             ld044,
  output logic             ld045,
  output logic             ld046,
  output logic             ld047,
  output ldFieldU          ldField
);

  // Registered strobe and one-hot load pulses
  // Load codes 0 and 1 fall through with no pulse
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      ctlStrobe <= 1'b0;
      ld042     <= 1'b0;
      ld043     <= 1'b0;
      ld044     <= 1'b0;
      ld045     <= 1'b0;
      ld046     <= 1'b0;
      ld047     <= 1'b0;
    end else begin
      ctlStrobe <= diagCtlFunc;
      ld042     <= diagLdFunc && (diagSel == LD_BURST_LO);
      ld043     <= diagLdFunc && (diagSel == LD_BURST_HI);
      ld044     <= diagLdFunc && (diagSel == LD_CLK_SEL);
      ld045     <= diagLdFunc && (diagSel == LD_DISABLE);
      ld046     <= diagLdFunc && (diagSel == LD_CHECK);
      ld047     <= diagLdFunc && (diagSel == LD_MBOX_CTL);
    end
  end

  // Code and data are captured alongside their strobes
  always_ff @(posedge MBOX_CLK) begin
    if (diagCtlFunc) begin
      ctlCode <= diagSel;
    end
    if (diagLdFunc) begin
      ldField.raw <= ebusData;
    end
  end

endmodule

//--- hw/clkCtlRegs.sv
`timescale 1ns/1ps

module clkCtlRegs import clkPkg::*; (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  input  logic               ctlStrobe,
  input  logic [SEL_W-1:0]   ctlCode,
  input  logic               ld042,
  input  logic               ld043,
  input  logic               ld044,
  input  logic               ld045,
  input  logic               ld046,
  input  logic               ld047,
  input  ldFieldU            ldField,
  input  logic               burstDec,
  output logic               go,
  output logic               burstMode,
  output logic               stepReq,
  output logic               mrReset,
  output logic               burstZero,
  output logic [BURST_W-1:0] burstCount,
  output logic [1:0]         sourceSel,
  output logic [1:0]         rateSel,
  output logic               crmDis,
  output logic               edpDis,
  output logic               ctlDis,
  output logic               fmParChk,
  output logic               cramParChk,
  output logic               dramParChk,
  output logic               fsChk,
  output logic               cycleDis,
  output logic               respSim,
  output logic               arArxParChk,
  output logic               errStopEn
);

  // Run mode flags
  // Any control function reloads both, so all but start/burst stop the clock
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      go        <= 1'b0;
      burstMode <= 1'b0;
    end else if (ctlStrobe) begin
      go        <= (ctlCode == FN_START);
      burstMode <= (ctlCode == FN_BURST);
    end
  end

  // Single step request, held until the gate issues its pulse
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stepReq <= 1'b0;
    end else if (ctlStrobe && (ctlCode == FN_SINGLE_STEP)) begin
      stepReq <= 1'b1;
    end else if (burstDec) begin
      stepReq <= 1'b0;
    end
  end

  // MR reset flip-flop, comes up asserted
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (ctlStrobe) begin
      if (ctlCode == FN_CLR_RESET) begin
        mrReset <= 1'b0;
      end else if (ctlCode == FN_SET_RESET) begin
        mrReset <= 1'b1;
      end
    end
  end

  // Burst counter
  // Nibble loads from 042/043, counts down once per burst pulse
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (ld042) begin
      burstCount[LD_W-1:0] <= ldField.raw;
    end else if (ld043) begin
      burstCount[BURST_W-1:LD_W] <= ldField.raw;
    end else if (burstDec && !burstZero) begin
      burstCount <= burstCount - 1'b1;
    end
  end

  assign burstZero = (burstCount == '0);

  // Load registers 044..047, each reading its own view of the nibble
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      sourceSel   <= 2'b00;
      rateSel     <= 2'b00;
      crmDis      <= 1'b0;
      edpDis      <= 1'b0;
      ctlDis      <= 1'b0;
      fmParChk    <= 1'b0;
      cramParChk  <= 1'b0;
      dramParChk  <= 1'b0;
      fsChk       <= 1'b0;
      cycleDis    <= 1'b0;
      respSim     <= 1'b0;
      arArxParChk <= 1'b0;
      errStopEn   <= 1'b0;
    end else begin
      // Clock source is stored for readback only
      if (ld044) begin
        sourceSel <= ldField.clkSel.sourceSel;
        rateSel   <= ldField.clkSel.rateSel;
      end
      if (ld045) begin
        crmDis <= ldField.disables.crmDis;
        edpDis <= ldField.disables.edpDis;
        ctlDis <= ldField.disables.ctlDis;
      end
      if (ld046) begin
        fmParChk   <= ldField.checks.fmParChk;
        cramParChk <= ldField.checks.cramParChk;
        dramParChk <= ldField.checks.dramParChk;
        fsChk      <= ldField.checks.fsChk;
      end
      if (ld047) begin
        cycleDis    <= ldField.mboxCtl.cycleDis;
        respSim     <= ldField.mboxCtl.respSim;
        arArxParChk <= ldField.mboxCtl.arArxParChk;
        errStopEn   <= ldField.mboxCtl.errStopEn;
      end
    end
  end

endmodule

//--- hw/clkRateGate.sv
`timescale 1ns/1ps

module clkRateGate (
  input  logic       MBOX_CLK,
  input  logic       CLK,
  input  logic       go,
  input  logic       burstMode,
  input  logic       stepReq,
  input  logic       burstZero,
  input  logic [1:0] rateSel,
  output logic       eboxClkEn,
  output logic       burstDec
);

  logic [2:0] prescale;
  logic       tick;

  // Free running prescaler, never stopped by mode changes
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      prescale <= 3'd0;
    end else begin
      prescale <= prescale + 3'd1;
    end
  end

  // Tick once every 1, 2, 4 or 8 cycles
  always_comb begin
    case (rateSel)
      2'd0:    tick = 1'b1;
      2'd1:    tick = (prescale[0] == 1'b0);
      2'd2:    tick = (prescale[1:0] == 2'b00);
      default: tick = (prescale == 3'd0);
    endcase
  end

  // Burst and step pulses consume a count or the step request
  // Issued a cycle ahead of the enable so the counter is
  // already updated when the next tick is judged
  assign burstDec = tick && ((burstMode && !burstZero) || stepReq);

  // Registered EBOX clock enable
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxClkEn <= 1'b0;
    end else begin
      eboxClkEn <= (tick && go) || burstDec;
    end
  end

endmodule

//--- hw/clkDiagRead.sv
`timescale 1ns/1ps

module clkDiagRead import clkPkg::*; (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  input  logic               diagRead,
  input  logic [SEL_W-1:0]   diagSel,
  input  logic               go,
  input  logic               burstMode,
  input  logic               stepReq,
  input  logic               mrReset,
  input  logic               burstZero,
  input  logic [BURST_W-1:0] burstCount,
  input  logic [1:0]         sourceSel,
  input  logic [1:0]         rateSel,
  input  logic               crmDis,
  input  logic               edpDis,
  input  logic               ctlDis,
  input  logic               fmParChk,
  input  logic               cramParChk,
  input  logic               dramParChk,
  input  logic               fsChk,
  input  logic               cycleDis,
  input  logic               respSim,
  input  logic               arArxParChk,
  input  logic               errStopEn,
  output logic [DIAG_W-1:0]  diagData,
  output logic               diagDriving
);

  logic [DIAG_W-1:0] rowData;

  // Row select, MSB first
  always_comb begin
    case (diagSel)
      ROW_RUN:      rowData = {go, burstMode, mrReset, burstZero, burstCount[BURST_W-1 -: 2]};
      ROW_BURST_LO: rowData = burstCount[DIAG_W-1:0];
      ROW_CLK_SEL:  rowData = {sourceSel, rateSel, stepReq, respSim};
      ROW_DIS_CHK:  rowData = {crmDis, edpDis, ctlDis, fmParChk, cramParChk, dramParChk};
      ROW_MBOX:     rowData = {fsChk, cycleDis, respSim, arArxParChk, errStopEn, burstMode};
      // Rows 5..7 read as zero
      default:      rowData = '0;
    endcase
  end

  // Bus is quiet and driver off unless a read is requested
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      diagData    <= '0;
      diagDriving <= 1'b0;
    end else begin
      diagData    <= diagRead ? rowData : '0;
      diagDriving <= diagRead;
    end
  end

endmodule

//--- hw/clkTop.sv
`timescale 1ns/1ps

module clkTop import clkPkg::*; (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  logic              diagCtlFunc,
  input  logic              diagLdFunc,
  input  logic [SEL_W-1:0]  diagSel,
  input  logic [LD_W-1:0]   ebusData,
  input  logic              diagRead,
  output logic              eboxClkEn,
  output logic              mrReset,
  output logic [DIAG_W-1:0] diagData,
  output logic              diagDriving
);

  // Decoder to registers
  logic             ctlStrobe;
  logic [SEL_W-1:0] ctlCode;
  logic             ld042;
  logic             ld043;
  logic             ld044;
  logic             ld045;
  logic             ld046;
  logic             ld047;
  ldFieldU          ldField;

  // Mode state between registers and gate
  logic               go;
  logic               burstMode;
  logic               stepReq;
  logic               burstZero;
  logic               burstDec;
  logic [BURST_W-1:0] burstCount;
  logic [1:0]         rateSel;

  // Stored status for readback
  logic [1:0] sourceSel;
  logic       crmDis;
  logic       edpDis;
  logic       ctlDis;
  logic       fmParChk;
  logic       cramParChk;
  logic       dramParChk;
  logic       fsChk;
  logic       cycleDis;
  logic       respSim;
  logic       arArxParChk;
  logic       errStopEn;

  clkFuncDecoder uDecoder (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diagCtlFunc (diagCtlFunc),
    .diagLdFunc  (diagLdFunc),
    .diagSel     (diagSel),
    .ebusData    (ebusData),
    .ctlStrobe   (ctlStrobe),
    .ctlCode     (ctlCode),
    .ld042       (ld042),
    .ld043       (ld043),
    .ld044       (ld044),
    .ld045       (ld045),
    .ld046       (ld046),
    .ld047       (ld047),
    .ldField     (ldField)
  );

  clkCtlRegs uCtlRegs (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .ctlStrobe   (ctlStrobe),
    .ctlCode     (ctlCode),
    .ld042       (ld042),
    .ld043       (ld043),
    .ld044       (ld044),
    .ld045       (ld045),
    .ld046       (ld046),
    .ld047       (ld047),
    .ldField     (ldField),
    .burstDec    (burstDec),
    .go          (go),
    .burstMode   (burstMode),
    .stepReq     (stepReq),
    .mrReset     (mrReset),
    .burstZero   (burstZero),
    .burstCount  (burstCount),
    .sourceSel   (sourceSel),
    .rateSel     (rateSel),
    .crmDis      (crmDis),
    .edpDis      (edpDis),
    .ctlDis      (ctlDis),
    .fmParChk    (fmParChk),
    .cramParChk  (cramParChk),
    .dramParChk  (dramParChk),
    .fsChk       (fsChk),
    .cycleDis    (cycleDis),
    .respSim     (respSim),
    .arArxParChk (arArxParChk),
    .errStopEn   (errStopEn)
  );

  clkRateGate uRateGate (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .go        (go),
    .burstMode (burstMode),
    .stepReq   (stepReq),
    .burstZero (burstZero),
    .rateSel   (rateSel),
    .eboxClkEn (eboxClkEn),
    .burstDec  (burstDec)
  );

  clkDiagRead uDiagRead (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .go          (go),
    .burstMode   (burstMode),
    .stepReq     (stepReq),
    .mrReset     (mrReset),
    .burstZero   (burstZero),
    .burstCount  (burstCount),
    .sourceSel   (sourceSel),
    .rateSel     (rateSel),
    .crmDis      (crmDis),
    .edpDis      (edpDis),
    .ctlDis      (ctlDis),
    .fmParChk    (fmParChk),
    .cramParChk  (cramParChk),
    .dramParChk  (dramParChk),
    .fsChk       (fsChk),
    .cycleDis    (cycleDis),
    .respSim     (respSim),
    .arArxParChk (arArxParChk),
    .errStopEn   (errStopEn),
    .diagData    (diagData),
    .diagDriving (diagDriving)
  );

endmodule

//--- test/clkTb.sv
`timescale 1ns/1ps

module clkTb import clkPkg::*; ();

  logic              MBOX_CLK;
  logic              CLK;
  logic              diagCtlFunc;
  logic              diagLdFunc;
  logic [SEL_W-1:0]  diagSel;
  logic [LD_W-1:0]   ebusData;
  logic              diagRead;
  logic              eboxClkEn;
  logic              mrReset;
  logic [DIAG_W-1:0] diagData;
  logic              diagDriving;

  // Shadow board state follows each issued strobe
  logic       mGo;
  logic       mBurst;
  logic       mStep;
  logic       mReset;
  logic [7:0] mCount;
  logic [3:0] mClkSel;
  logic [3:0] mDis;
  logic [3:0] mChk;
  logic [3:0] mMbox;

  int   errCount;
  int   checkCount;
  int   timeoutCount;
  logic checkOn;
  logic expDriving;

  clkTop UUT (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diagCtlFunc (diagCtlFunc),
    .diagLdFunc  (diagLdFunc),
    .diagSel     (diagSel),
    .ebusData    (ebusData),
    .diagRead    (diagRead),
    .eboxClkEn   (eboxClkEn),
    .mrReset     (mrReset),
    .diagData    (diagData),
    .diagDriving (diagDriving)
  );

  initial begin
    MBOX_CLK = 1'b0;
    forever #10 MBOX_CLK = ~MBOX_CLK;
  end

  // Expected row for the shadow state with the MSB first
  function automatic logic [5:0] diagRef(input logic [2:0] row);
    case (row)
      3'd0:    diagRef = {mGo, mBurst, mReset, (mCount == 8'd0), mCount[7:6]};
      3'd1:    diagRef = mCount[5:0];
      3'd2:    diagRef = {mClkSel, mStep, mMbox[2]};
      3'd3:    diagRef = {mDis[2:0], mChk[3:1]};
      3'd4:    diagRef = {mChk[0], mMbox, mBurst};
      default: diagRef = 6'd0;
    endcase
  endfunction

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timed out waiting for %s", what);
    timeoutCount++;
  endtask

  // Driver is registered one cycle behind the read request
  always @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      expDriving <= 1'b0;
    end else begin
      expDriving <= diagRead;
    end
  end

  // Continuous compare of the bus driver and the idle bus
  always @(negedge MBOX_CLK) begin
    if (checkOn) begin
      checkVal("diagDriving", diagDriving, expDriving);
      if (!expDriving) begin
        checkVal("diagData idle", diagData, 6'd0);
      end
    end
  end

  // All stimulus tasks start and end on a falling edge
  task automatic issueCtl(input logic [2:0] code);
    diagCtlFunc = 1'b1;
    diagSel     = code;
    @(negedge MBOX_CLK);
    diagCtlFunc = 1'b0;
    mGo    = (code == FN_START);
    mBurst = (code == FN_BURST);
    if (code == FN_SINGLE_STEP) begin
      mStep = 1'b1;
    end
    if (code == FN_CLR_RESET) begin
      mReset = 1'b0;
    end else if (code == FN_SET_RESET) begin
      mReset = 1'b1;
    end
  endtask

  task automatic issueLd(input logic [2:0] code, input logic [3:0] data);
    diagLdFunc = 1'b1;
    diagSel    = code;
    ebusData   = data;
    @(negedge MBOX_CLK);
    diagLdFunc = 1'b0;
    case (code)
      LD_BURST_LO: mCount[3:0] = data;
      LD_BURST_HI: mCount[7:4] = data;
      LD_CLK_SEL:  mClkSel = data;
      LD_DISABLE:  mDis = data;
      LD_CHECK:    mChk = data;
      LD_MBOX_CTL: mMbox = data;
      default:     ;
    endcase
  endtask

  // One idle cycle first so a preceding strobe has landed in the registers
  task automatic checkRow(input logic [2:0] row);
    @(negedge MBOX_CLK);
    diagRead = 1'b1;
    diagSel  = row;
    @(negedge MBOX_CLK);
    checkVal($sformatf("diagData row %0d", row), diagData, diagRef(row));
    diagRead = 1'b0;
  endtask

  task automatic waitPulse(input int limit, output int cycles, output bit seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge MBOX_CLK);
      cycles++;
      seen = eboxClkEn;
    end
  endtask

  task automatic expectQuiet(input int span, input string phase);
    for (int k = 0; k < span; k++) begin
      @(negedge MBOX_CLK);
      checkVal($sformatf("eboxClkEn in %s", phase), eboxClkEn, 1'b0);
    end
  endtask

  initial begin
    int          rate;
    int          n;
    int          cyc;
    bit          seen;

    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    diagSel     = '0;
    ebusData    = '0;
    diagRead    = 1'b0;
    CLK         = 1'b1;
    checkOn     = 1'b0;
    errCount    = 0;
    checkCount  = 0;
    timeoutCount = 0;
    {mGo, mBurst, mStep, mCount} = '0;
    {mClkSel, mDis, mChk, mMbox} = '0;
    mReset  = 1'b1;
    void'($urandom(32'h4cee));

    repeat (3) @(posedge MBOX_CLK);
    @(negedge MBOX_CLK);
    CLK     = 1'b0;
    checkOn = 1'b1;

    // Reset state has a quiet clock and mrReset up
    expectQuiet(20, "reset idle");
    checkRow(3'd0);
    checkVal("mrReset", mrReset, 1'b1);

    // Random load registers read back through rows 2 to 4
    issueLd(LD_CLK_SEL, 4'($urandom));
    issueLd(LD_DISABLE, 4'($urandom));
    issueLd(LD_CHECK, 4'($urandom));
    issueLd(LD_MBOX_CTL, 4'($urandom));
    for (int r = 2; r <= 4; r++) begin
      checkRow(3'(r));
    end

    // Burst of n pulses at a random rate
    rate = $urandom_range(3, 0);
    n    = $urandom_range(40, 1);
    issueLd(LD_CLK_SEL, {2'($urandom), 2'(rate)});
    issueLd(LD_BURST_LO, 4'(n));
    issueLd(LD_BURST_HI, 4'(n >> 4));
    checkRow(3'd1);
    issueCtl(FN_BURST);
    waitPulse(12, cyc, seen);
    if (!seen) begin
      reportTimeout("first burst pulse");
    end
    for (int i = 1; i < n && seen; i++) begin
      waitPulse((1 << rate) + 4, cyc, seen);
      if (!seen) begin
        reportTimeout($sformatf("burst pulse %0d of %0d", i + 1, n));
      end else begin
        checkVal("burst pulse spacing", cyc, 1 << rate);
      end
    end
    // Every burst pulse took one count
    mCount = 8'd0;
    expectQuiet(30, "burst tail");
    checkRow(3'd0);
    checkRow(3'd1);

    // Single step gives one pulse and then nothing
    issueCtl(FN_SINGLE_STEP);
    waitPulse(10, cyc, seen);
    if (!seen) begin
      reportTimeout("single step pulse");
    end
    mStep = 1'b0;
    expectQuiet(30, "single step tail");
    checkRow(3'd2);

    // Free run at the rate spacing
    issueCtl(FN_START);
    waitPulse(12, cyc, seen);
    if (!seen) begin
      reportTimeout("first run pulse");
    end
    for (int i = 0; i < 3 && seen; i++) begin
      waitPulse((1 << rate) + 4, cyc, seen);
      if (!seen) begin
        reportTimeout("run pulse");
      end else begin
        checkVal("run pulse spacing", cyc, 1 << rate);
      end
    end

    // Clear reset stops the run within one rate period
    issueCtl(FN_CLR_RESET);
    repeat (1 << rate) @(negedge MBOX_CLK);
    expectQuiet(30, "stopped run");
    checkRow(3'd0);
    checkVal("mrReset", mrReset, 1'b0);

    // Set reset brings mrReset back
    issueCtl(FN_SET_RESET);
    checkRow(3'd0);
    checkVal("mrReset", mrReset, 1'b1);

    repeat (2) @(negedge MBOX_CLK);
    checkOn = 1'b0;
    $display("Checks %0d, errors %0d, timeouts %0d", checkCount, errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
hw/clkPkg.sv
hw/clkFuncDecoder.sv
hw/clkCtlRegs.sv
hw/clkRateGate.sv
hw/clkDiagRead.sv
hw/clkTop.sv
test/clkTb.sv

//--- Bender.yml
package:
  name: clkBoard

sources:
  - files:
      - hw/clkPkg.sv
      - hw/clkFuncDecoder.sv
      - hw/clkCtlRegs.sv
      - hw/clkRateGate.sv
      - hw/clkDiagRead.sv
      - hw/clkTop.sv
  - target: test
    files:
      - test/clkTb.sv
